// ==== Bender.yml ====
package:
  name: core_perf_monitor

sources:
  - include_dirs:
      - logic
    files:
      - logic/perf_monitor_pkg.sv
      - logic/read_latency_tracker.sv
      - logic/dcache_traffic_monitor.sv
      - logic/perf_csr_axil.sv
      - logic/core_perf_monitor.sv
  - target: simulation
    include_dirs:
      - logic
      - verif
    files:
      - verif/tb_core_perf_monitor.sv

// ==== logic/core_perf_monitor.sv ====
/* memory traffic monitor for one core: instruction fetch and data cache lanes
   counters read and cleared over AXI4-Lite; fires count one cycle later */

`timescale 1ns/100ps
`default_nettype none

`include "perf_monitor_config.svh"

module core_perf_monitor
    import perf_monitor_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,

    input  wire logic                       icache_req_valid,
    input  wire logic                       icache_req_ready,
    input  wire logic                       icache_rsp_valid,
    input  wire logic                       icache_rsp_ready,

    input  wire lane_vec_t                  dcache_req_valid,
    input  wire lane_vec_t                  dcache_req_ready,
    input  wire lane_vec_t                  dcache_req_rw,
    input  wire lane_vec_t                  dcache_rsp_valid,
    input  wire lane_vec_t                  dcache_rsp_ready,

    input  wire logic                       s_axil_awvalid,
    output wire logic                       s_axil_awready,
    input  wire logic [`AXIL_ADDR_BITS-1:0] s_axil_awaddr,
    input  wire logic                       s_axil_wvalid,
    output wire logic                       s_axil_wready,
    input  wire logic [`AXIL_DATA_BITS-1:0] s_axil_wdata,
    output wire logic                       s_axil_bvalid,
    input  wire logic                       s_axil_bready,
    output wire axil_resp_t                 s_axil_bresp,
    input  wire logic                       s_axil_arvalid,
    output wire logic                       s_axil_arready,
    input  wire logic [`AXIL_ADDR_BITS-1:0] s_axil_araddr,
    output wire logic                       s_axil_rvalid,
    input  wire logic                       s_axil_rready,
    output wire logic [`AXIL_DATA_BITS-1:0] s_axil_rdata,
    output wire axil_resp_t                 s_axil_rresp
);

    wire perf_ctr_t ifetches;
    wire perf_ctr_t ifetch_latency;
    wire perf_ctr_t loads;
    wire perf_ctr_t load_latency;
    wire perf_ctr_t stores;
    wire logic      clear;

    // instruction side is a single read lane
    read_latency_tracker #(
        .NUM_LANES (1)
    ) icache_tracker (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .req_fire (icache_req_valid & icache_req_ready),
        .rsp_fire (icache_rsp_valid & icache_rsp_ready),
        .reads    (ifetches),
        .latency  (ifetch_latency)
    );

    dcache_traffic_monitor dcache_monitor (
        .clk              (clk),
        .reset            (reset),
        .clear            (clear),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_ready (dcache_req_ready),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .loads            (loads),
        .load_latency     (load_latency),
        .stores           (stores)
    );

    perf_csr_axil csr (
        .clk            (clk),
        .reset          (reset),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .ifetches       (ifetches),
        .ifetch_latency (ifetch_latency),
        .loads          (loads),
        .load_latency   (load_latency),
        .stores         (stores),
        .clear          (clear)
    );

endmodule

`default_nettype wire

// ==== logic/dcache_traffic_monitor.sv ====
/* splits data cache lane traffic into loads and stores
   rw high marks a store; stores get no response and add no latency */

`timescale 1ns/100ps
`default_nettype none

module dcache_traffic_monitor
    import perf_monitor_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      clear,

    input  wire lane_vec_t dcache_req_valid,
    input  wire lane_vec_t dcache_req_ready,
    input  wire lane_vec_t dcache_req_rw,
    input  wire lane_vec_t dcache_rsp_valid,
    input  wire lane_vec_t dcache_rsp_ready,

    output wire perf_ctr_t loads,
    output wire perf_ctr_t load_latency,
    output perf_ctr_t      stores
);

    lane_vec_t req_fire;
    lane_vec_t load_fire;
    lane_vec_t store_fire;
    lane_vec_t rsp_fire;

    // per lane handshakes
    assign req_fire   = dcache_req_valid & dcache_req_ready;
    assign load_fire  = req_fire & ~dcache_req_rw;
    assign store_fire = req_fire & dcache_req_rw;
    assign rsp_fire   = dcache_rsp_valid & dcache_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            stores <= '0;
        end else begin
            stores <= stores + pop_count(store_fire);
        end
    end

    // loads and their responses go through the shared tracker
    read_latency_tracker #(
        .NUM_LANES ($bits(lane_vec_t))
    ) load_tracker (
        .clk      (clk),
        .reset    (reset),
        .clear    (clear),
        .req_fire (load_fire),
        .rsp_fire (rsp_fire),
        .reads    (loads),
        .latency  (load_latency)
    );

endmodule

`default_nettype wire

// ==== logic/perf_csr_axil.sv ====
/* AXI4-Lite counter registers; master presents write address and data together
   a low half read snapshots the high half; no wstrb, writes are full words */

`timescale 1ns/100ps
`default_nettype none

`include "perf_monitor_config.svh"

module perf_csr_axil
    import perf_monitor_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       reset,

    input  wire logic                       s_axil_awvalid,
    output logic                            s_axil_awready,
    input  wire logic [`AXIL_ADDR_BITS-1:0] s_axil_awaddr,
    input  wire logic                       s_axil_wvalid,
    output logic                            s_axil_wready,
    input  wire logic [`AXIL_DATA_BITS-1:0] s_axil_wdata,
    output logic                            s_axil_bvalid,
    input  wire logic                       s_axil_bready,
    output axil_resp_t                      s_axil_bresp,
    input  wire logic                       s_axil_arvalid,
    output logic                            s_axil_arready,
    input  wire logic [`AXIL_ADDR_BITS-1:0] s_axil_araddr,
    output logic                            s_axil_rvalid,
    input  wire logic                       s_axil_rready,
    output logic [`AXIL_DATA_BITS-1:0]      s_axil_rdata,
    output axil_resp_t                      s_axil_rresp,

    input  wire perf_ctr_t                  ifetches,
    input  wire perf_ctr_t                  ifetch_latency,
    input  wire perf_ctr_t                  loads,
    input  wire perf_ctr_t                  load_latency,
    input  wire perf_ctr_t                  stores,

    output logic                            clear
);

    localparam int NUM_CTRS = 5;
    localparam int HI_BITS  = `PERF_CTR_BITS - `AXIL_DATA_BITS;
    localparam logic [2:0] SEL_NONE = 3'd7;

    // counter index for a word address, SEL_NONE when not a counter
    function automatic logic [2:0] ctr_sel(input logic [`AXIL_ADDR_BITS-1:0] addr);
        logic [`AXIL_ADDR_BITS-1:0] base;
        base = {addr[`AXIL_ADDR_BITS-1:3], 3'b000};
        if (addr[1:0] != 2'b00) begin
            return SEL_NONE;
        end
        case (base)
            `REG_IFETCH:     return 3'd0;
            `REG_IFETCH_LAT: return 3'd1;
            `REG_LOADS:      return 3'd2;
            `REG_LOAD_LAT:   return 3'd3;
            `REG_STORES:     return 3'd4;
            default:         return SEL_NONE;
        endcase
    endfunction

    perf_ctr_t                  ctr [NUM_CTRS];
    logic [HI_BITS-1:0]         hi_snap [NUM_CTRS];
    logic                       wr_fire;
    logic                       wr_ctrl;
    logic                       wr_mapped;
    logic                       rd_fire;
    logic [2:0]                 rd_sel;
    logic                       rd_hi;
    logic [`AXIL_DATA_BITS-1:0] rd_value;
    axil_resp_t                 rd_resp;

    assign ctr = '{ifetches, ifetch_latency, loads, load_latency, stores};

    // write channel, one transaction in flight
    assign s_axil_awready = !s_axil_bvalid;
    assign s_axil_wready  = !s_axil_bvalid;
    assign wr_fire   = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign wr_ctrl   = (s_axil_awaddr == `REG_CTRL);
    assign wr_mapped = wr_ctrl || (ctr_sel(s_axil_awaddr) != SEL_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            s_axil_bvalid <= 1'b0;
            clear         <= 1'b0;
        end else begin
            if (wr_fire) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            // one-cycle pulse after the write
            clear <= wr_fire && wr_ctrl && s_axil_wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            s_axil_bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // read channel
    assign s_axil_arready = !s_axil_rvalid;
    assign rd_fire = s_axil_arvalid && !s_axil_rvalid;
    assign rd_sel  = ctr_sel(s_axil_araddr);
    assign rd_hi   = s_axil_araddr[2];

    always_comb begin
        rd_value = '0;
        rd_resp  = RESP_SLVERR;
        if (s_axil_araddr == `REG_CTRL) begin
            // clear self-resets, control reads back as zero
            rd_resp = RESP_OKAY;
        end else if (rd_sel != SEL_NONE) begin
            rd_resp = RESP_OKAY;
            if (rd_hi) begin
                rd_value = `AXIL_DATA_BITS'(hi_snap[rd_sel]);
            end else begin
                rd_value = ctr[rd_sel][`AXIL_DATA_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_axil_rdata <= rd_value;
            s_axil_rresp <= rd_resp;
        end
    end

    // high half frozen with the low half so a 64-bit read is coherent
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_CTRS; i++) begin
                hi_snap[i] <= '0;
            end
        end else if (rd_fire && rd_sel != SEL_NONE && !rd_hi) begin
            hi_snap[rd_sel] <= ctr[rd_sel][`PERF_CTR_BITS-1:`AXIL_DATA_BITS];
        end
    end

    rdata_held: assert property (
        @(posedge clk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata)
    ) else $error("read data changed under back-pressure");

endmodule

`default_nettype wire

// ==== logic/perf_monitor_config.svh ====
/* build-time sizing of the performance monitor
   PERF_CTR_BITS must lie between AXIL_DATA_BITS+1 and 2*AXIL_DATA_BITS */

`ifndef PERF_MONITOR_CONFIG_SVH
`define PERF_MONITOR_CONFIG_SVH

// data cache request lanes
`define DCACHE_NUM_LANES 4

// counter width, split into a low and a high register word
`define PERF_CTR_BITS 44

`define AXIL_ADDR_BITS 8
`define AXIL_DATA_BITS 32

// byte offsets, high half of each counter at offset + 4
`define REG_CTRL       `AXIL_ADDR_BITS'h00
`define REG_IFETCH     `AXIL_ADDR_BITS'h08
`define REG_IFETCH_LAT `AXIL_ADDR_BITS'h10
`define REG_LOADS      `AXIL_ADDR_BITS'h18
`define REG_LOAD_LAT   `AXIL_ADDR_BITS'h20
`define REG_STORES     `AXIL_ADDR_BITS'h28

`endif

// ==== logic/perf_monitor_pkg.sv ====
/* shared types of the performance monitor
   pop_count covers at most DCACHE_NUM_LANES fire bits */

`default_nettype none

`include "perf_monitor_config.svh"

package perf_monitor_pkg;

    typedef logic [`PERF_CTR_BITS-1:0] perf_ctr_t;

    // one fire bit per data cache lane
    typedef logic [`DCACHE_NUM_LANES-1:0] lane_vec_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // number of set bits, already at counter width
    function automatic perf_ctr_t pop_count(input lane_vec_t fires);
        perf_ctr_t n;
        n = '0;
        for (int i = 0; i < `DCACHE_NUM_LANES; i++) begin
            n = n + perf_ctr_t'(fires[i]);
        end
        return n;
    endfunction

endpackage

`default_nettype wire

// ==== logic/read_latency_tracker.sv ====
/* counts read requests and sums outstanding reads per cycle as latency
   NUM_LANES may not exceed DCACHE_NUM_LANES; clear keeps in-flight reads */

`timescale 1ns/100ps
`default_nettype none

module read_latency_tracker
    import perf_monitor_pkg::*;
#(
    parameter int NUM_LANES = 1
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 clear,

    input  wire logic [NUM_LANES-1:0] req_fire,
    input  wire logic [NUM_LANES-1:0] rsp_fire,

    output perf_ctr_t                 reads,
    output perf_ctr_t                 latency
);

    perf_ctr_t req_cnt;
    perf_ctr_t rsp_cnt;
    perf_ctr_t outstanding;

    if (NUM_LANES > $bits(lane_vec_t)) begin : g_lane_check
        $error("read_latency_tracker: NUM_LANES wider than the lane vector");
    end

    // fires of this cycle, zero extended to the lane vector
    assign req_cnt = pop_count(lane_vec_t'(req_fire));
    assign rsp_cnt = pop_count(lane_vec_t'(rsp_fire));

    // reads in flight, untouched by clear
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + req_cnt - rsp_cnt;
        end
    end

    // latency adds the count that held before this edge
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            reads   <= '0;
            latency <= '0;
        end else begin
            reads   <= reads + req_cnt;
            latency <= latency + outstanding;
        end
    end

    // a response always belongs to a read accepted in an earlier cycle
    rsp_within_outstanding: assert property (
        @(posedge clk) disable iff (reset)
        rsp_cnt <= outstanding
    ) else $error("more read responses than outstanding reads");

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
+incdir+verif
logic/perf_monitor_pkg.sv
logic/read_latency_tracker.sv
logic/dcache_traffic_monitor.sv
logic/perf_csr_axil.sv
logic/core_perf_monitor.sv
verif/tb_core_perf_monitor.sv

// ==== verif/tb_axil_tasks.svh ====
/* AXI4-Lite master tasks and random source included inside the testbench module
   tasks start and end 1 ns after a rising edge; HS_LIMIT bounds each handshake */

`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

localparam int HS_LIMIT = 32;

logic [31:0] lcg_state = 32'haedb;

// 32-bit LCG whose upper bits are used
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic chance(input int pct);
    return ((lcg_next() >> 16) % 100) < pct;
endfunction

// address and data presented together with bready held low for hold cycles
task automatic axil_write(input logic [`AXIL_ADDR_BITS-1:0] addr,
                          input logic [`AXIL_DATA_BITS-1:0] data,
                          input int hold, output axil_resp_t resp);
    int n;
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = (hold == 0);
    n = 0;
    @(posedge clk);
    while (!(s_axil_awready && s_axil_wready) && n < HS_LIMIT) begin
        @(posedge clk);
        n++;
    end
    if (n >= HS_LIMIT) begin
        $display("write to 0x%02h was never accepted in %s", addr, test_name);
        errors++;
    end
    #1;
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    for (int i = 0; i < hold; i++) begin
        if (s_axil_awready || s_axil_wready) begin
            $display("write channel ready while a response was pending in %s", test_name);
            errors++;
        end
        @(posedge clk);
        #1;
    end
    s_axil_bready = 1'b1;
    n = 0;
    @(posedge clk);
    while (!s_axil_bvalid && n < HS_LIMIT) begin
        @(posedge clk);
        n++;
    end
    if (n >= HS_LIMIT) begin
        $display("no write response for 0x%02h in %s", addr, test_name);
        errors++;
    end
    resp = s_axil_bresp;
    #1;
    s_axil_bready = 1'b0;
endtask

// rready held low for hold cycles after the address is taken
task automatic axil_read(input logic [`AXIL_ADDR_BITS-1:0] addr, input int hold,
                         output logic [`AXIL_DATA_BITS-1:0] data, output axil_resp_t resp);
    int n;
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    s_axil_rready  = (hold == 0);
    n = 0;
    @(posedge clk);
    while (!s_axil_arready && n < HS_LIMIT) begin
        @(posedge clk);
        n++;
    end
    if (n >= HS_LIMIT) begin
        $display("read of 0x%02h was never accepted in %s", addr, test_name);
        errors++;
    end
    #1;
    s_axil_arvalid = 1'b0;
    for (int i = 0; i < hold; i++) begin
        if (s_axil_arready) begin
            $display("read channel ready while a response was pending in %s", test_name);
            errors++;
        end
        @(posedge clk);
        #1;
    end
    s_axil_rready = 1'b1;
    n = 0;
    @(posedge clk);
    while (!s_axil_rvalid && n < HS_LIMIT) begin
        @(posedge clk);
        n++;
    end
    if (n >= HS_LIMIT) begin
        $display("no read response for 0x%02h in %s", addr, test_name);
        errors++;
    end
    data = s_axil_rdata;
    resp = s_axil_rresp;
    #1;
    s_axil_rready = 1'b0;
endtask

`endif

// ==== verif/tb_core_perf_monitor.sv ====
/* testbench for core_perf_monitor with random traffic against a cycle model
   inputs change 1 ns after the rising edge; counters stay far below 2^32 */

`timescale 1ns/100ps
`default_nettype none

`include "perf_monitor_config.svh"

module tb_core_perf_monitor
    import perf_monitor_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int IFETCH_CYCLES = 300;
    localparam int DCACHE_CYCLES = 300;
    localparam int STORE_CYCLES  = 40;
    localparam int HOLD_CYCLES   = 12;
    localparam int DRAIN_LIMIT   = 200;
    localparam int NUM_READS     = 40;
    localparam int READ_CYCLES   = 12;
    localparam int TEST_CYCLES   = RESET_CYCLES + IFETCH_CYCLES + DCACHE_CYCLES + STORE_CYCLES
                                 + HOLD_CYCLES + 4 * DRAIN_LIMIT + NUM_READS * READ_CYCLES;

    logic clk;
    logic reset;
    logic icache_req_valid;
    logic icache_req_ready;
    logic icache_rsp_valid;
    logic icache_rsp_ready;
    lane_vec_t dcache_req_valid;
    lane_vec_t dcache_req_ready;
    lane_vec_t dcache_req_rw;
    lane_vec_t dcache_rsp_valid;
    lane_vec_t dcache_rsp_ready;
    logic s_axil_awvalid;
    logic [`AXIL_ADDR_BITS-1:0] s_axil_awaddr;
    logic s_axil_wvalid;
    logic [`AXIL_DATA_BITS-1:0] s_axil_wdata;
    logic s_axil_bready;
    logic s_axil_arvalid;
    logic [`AXIL_ADDR_BITS-1:0] s_axil_araddr;
    logic s_axil_rready;
    wire logic s_axil_awready;
    wire logic s_axil_wready;
    wire logic s_axil_bvalid;
    wire axil_resp_t s_axil_bresp;
    wire logic s_axil_arready;
    wire logic s_axil_rvalid;
    wire logic [`AXIL_DATA_BITS-1:0] s_axil_rdata;
    wire axil_resp_t s_axil_rresp;

    int errors;
    int checks;
    int errors_at_start;
    int checks_at_start;
    string test_name;

    // model counters in register order ifetch, ifetch_lat, loads, load_lat, stores
    perf_ctr_t m_ctr [5];
    perf_ctr_t m_if_out;
    perf_ctr_t m_ld_out;
    logic [`AXIL_DATA_BITS-1:0] m_snap [5];
    logic m_clear;
    logic if_req;
    logic if_rsp;
    lane_vec_t ld_fire;
    lane_vec_t st_fire;
    lane_vec_t ld_rsp;

    // compare process state
    logic [`AXIL_DATA_BITS-1:0] exp_data;
    logic [`AXIL_DATA_BITS-1:0] held_data;
    axil_resp_t exp_resp;
    logic [`AXIL_ADDR_BITS-1:0] rd_offset;
    logic rsp_seen;

    `include "tb_axil_tasks.svh"

    core_perf_monitor core_perf_monitor_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic perf_ctr_t count_fires(input lane_vec_t v);
        perf_ctr_t n;
        n = '0;
        for (int i = 0; i < `DCACHE_NUM_LANES; i++) begin
            n = n + v[i];
        end
        return n;
    endfunction

    // register map gives -1 for anything that is not a counter word
    function automatic int ctr_index(input logic [`AXIL_ADDR_BITS-1:0] offset);
        if (offset[1:0] != 2'b00) begin
            return -1;
        end
        case ({offset[`AXIL_ADDR_BITS-1:3], 3'b000})
            `REG_IFETCH:     return 0;
            `REG_IFETCH_LAT: return 1;
            `REG_LOADS:      return 2;
            `REG_LOAD_LAT:   return 3;
            `REG_STORES:     return 4;
            default:         return -1;
        endcase
    endfunction

    function automatic logic [`AXIL_DATA_BITS-1:0] expected_reg(
        input logic [`AXIL_ADDR_BITS-1:0] offset
    );
        int idx;
        idx = ctr_index(offset);
        if (idx < 0) begin
            return '0;
        end
        if (offset[2]) begin
            return m_snap[idx];
        end
        return m_ctr[idx][`AXIL_DATA_BITS-1:0];
    endfunction

    function automatic axil_resp_t expected_resp(input logic [`AXIL_ADDR_BITS-1:0] offset);
        if (offset == `REG_CTRL || ctr_index(offset) >= 0) begin
            return RESP_OKAY;
        end
        return RESP_SLVERR;
    endfunction

    assign if_req  = icache_req_valid & icache_req_ready;
    assign if_rsp  = icache_rsp_valid & icache_rsp_ready;
    assign ld_fire = dcache_req_valid & dcache_req_ready & ~dcache_req_rw;
    assign st_fire = dcache_req_valid & dcache_req_ready & dcache_req_rw;
    assign ld_rsp  = dcache_rsp_valid & dcache_rsp_ready;

    // cycle model of the counters
    always @(posedge clk) begin : model
        int idx;
        idx = ctr_index(s_axil_araddr);
        if (reset) begin
            m_clear  <= 1'b0;
            m_if_out <= '0;
            m_ld_out <= '0;
            for (int i = 0; i < 5; i++) begin
                m_ctr[i]  <= '0;
                m_snap[i] <= '0;
            end
        end else begin
            m_clear <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid
                       && s_axil_awaddr == `REG_CTRL && s_axil_wdata[0];
            m_if_out <= m_if_out + if_req - if_rsp;
            m_ld_out <= m_ld_out + count_fires(ld_fire) - count_fires(ld_rsp);
            if (m_clear) begin
                for (int i = 0; i < 5; i++) begin
                    m_ctr[i] <= '0;
                end
            end else begin
                m_ctr[0] <= m_ctr[0] + if_req;
                m_ctr[1] <= m_ctr[1] + m_if_out;
                m_ctr[2] <= m_ctr[2] + count_fires(ld_fire);
                m_ctr[3] <= m_ctr[3] + m_ld_out;
                m_ctr[4] <= m_ctr[4] + count_fires(st_fire);
            end
            // a low half read freezes the high half
            if (s_axil_arvalid && s_axil_arready && idx >= 0 && !s_axil_araddr[2]) begin
                m_snap[idx] <= `AXIL_DATA_BITS'(m_ctr[idx] >> `AXIL_DATA_BITS);
            end
        end
    end

    // every read response against the value expected at acceptance
    always @(posedge clk) begin
        if (reset) begin
            rsp_seen <= 1'b0;
        end else begin
            if (s_axil_arvalid && s_axil_arready) begin
                exp_data  <= expected_reg(s_axil_araddr);
                exp_resp  <= expected_resp(s_axil_araddr);
                rd_offset <= s_axil_araddr;
            end
            if (s_axil_rvalid) begin
                if (!rsp_seen) begin
                    held_data <= s_axil_rdata;
                end else if (s_axil_rdata !== held_data) begin
                    $display("read data changed while rready was low in %s", test_name);
                    errors++;
                end
                rsp_seen <= !s_axil_rready;
            end
            if (s_axil_rvalid && s_axil_rready) begin
                checks++;
                if (s_axil_rdata !== exp_data || s_axil_rresp !== exp_resp) begin
                    $display("CHECK FAILED %s: offset 0x%02h expected 0x%08h/%0d actual 0x%08h/%0d",
                             test_name, rd_offset, exp_data, exp_resp, s_axil_rdata,
                             s_axil_rresp);
                    errors++;
                end
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: %s expected 0x%08h actual 0x%08h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        checks_at_start = checks;
    endtask

    task automatic end_test();
        $display("test %-16s %0d checks, %0d errors", test_name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    task automatic read_reg(input logic [`AXIL_ADDR_BITS-1:0] addr);
        logic [31:0] data;
        axil_resp_t resp;
        axil_read(addr, 0, data, resp);
    endtask

    task automatic run_icache(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            icache_req_valid = chance(50);
            icache_req_ready = chance(60);
            // responses only for fetches already in flight
            icache_rsp_valid = (m_if_out != 0) && chance(70);
            icache_rsp_ready = chance(80);
            @(posedge clk);
            #1;
        end
        icache_req_valid = 1'b0;
        icache_rsp_valid = 1'b0;
    endtask

    task automatic run_dcache(input int cycles, input int store_pct);
        perf_ctr_t budget;
        for (int c = 0; c < cycles; c++) begin
            budget = m_ld_out;
            for (int i = 0; i < `DCACHE_NUM_LANES; i++) begin
                dcache_req_valid[i] = chance(50);
                dcache_req_ready[i] = chance(60);
                dcache_req_rw[i]    = chance(store_pct);
                dcache_rsp_valid[i] = (budget != 0) && chance(60);
                dcache_rsp_ready[i] = chance(80);
                if (dcache_rsp_valid[i] && dcache_rsp_ready[i]) begin
                    budget = budget - 1;
                end
            end
            @(posedge clk);
            #1;
        end
        dcache_req_valid = '0;
        dcache_rsp_valid = '0;
    endtask

    // fetches and loads that get no response yet
    task automatic issue_reads(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            icache_req_valid = 1'b1;
            icache_req_ready = 1'b1;
            dcache_req_valid = '1;
            dcache_req_ready = '1;
            dcache_req_rw    = '0;
            @(posedge clk);
            #1;
        end
        icache_req_valid = 1'b0;
        dcache_req_valid = '0;
    endtask

    task automatic drain();
        int n;
        perf_ctr_t budget;
        n = 0;
        icache_req_valid = 1'b0;
        dcache_req_valid = '0;
        icache_rsp_ready = 1'b1;
        dcache_rsp_ready = '1;
        while ((m_if_out != 0 || m_ld_out != 0) && n < DRAIN_LIMIT) begin
            icache_rsp_valid = (m_if_out != 0);
            budget = m_ld_out;
            for (int i = 0; i < `DCACHE_NUM_LANES; i++) begin
                dcache_rsp_valid[i] = (budget != 0);
                if (budget != 0) begin
                    budget = budget - 1;
                end
            end
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= DRAIN_LIMIT) begin
            $display("outstanding reads did not drain in %s", test_name);
            errors++;
        end
        icache_rsp_valid = 1'b0;
        dcache_rsp_valid = '0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] lat_before;
        axil_resp_t resp;
        errors           = 0;
        checks           = 0;
        reset            = 1'b1;
        icache_req_valid = 1'b0;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_ready = 1'b0;
        dcache_req_valid = '0;
        dcache_req_ready = '0;
        dcache_req_rw    = '0;
        dcache_rsp_valid = '0;
        dcache_rsp_ready = '0;
        s_axil_awvalid   = 1'b0;
        s_axil_awaddr    = '0;
        s_axil_wvalid    = 1'b0;
        s_axil_wdata     = '0;
        s_axil_bready    = 1'b0;
        s_axil_arvalid   = 1'b0;
        s_axil_araddr    = '0;
        s_axil_rready    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("reset_values");
        for (int off = `REG_IFETCH; off <= `REG_STORES + 4; off += 4) begin
            axil_read(`AXIL_ADDR_BITS'(off), 0, data, resp);
            check_value("counter after reset", '0, data);
            check_value("response after reset", RESP_OKAY, resp);
        end
        end_test();

        start_test("ifetch_traffic");
        run_icache(IFETCH_CYCLES);
        drain();
        read_reg(`REG_IFETCH);
        read_reg(`REG_IFETCH + 4);
        read_reg(`REG_IFETCH_LAT);
        read_reg(`REG_IFETCH_LAT + 4);
        end_test();

        start_test("dcache_traffic");
        run_dcache(DCACHE_CYCLES, 40);
        drain();
        read_reg(`REG_LOADS);
        read_reg(`REG_LOADS + 4);
        read_reg(`REG_STORES);
        read_reg(`REG_STORES + 4);
        read_reg(`REG_LOAD_LAT + 4);
        axil_read(`REG_LOAD_LAT, 0, lat_before, resp);
        run_dcache(STORE_CYCLES, 100);
        drain();
        axil_read(`REG_LOAD_LAT, 0, data, resp);
        check_value("load latency across stores", lat_before, data);
        read_reg(`REG_STORES);
        end_test();

        start_test("clear_in_flight");
        issue_reads(5);
        axil_write(`REG_CTRL, 32'h1, 0, resp);
        check_value("clear write response", RESP_OKAY, resp);
        axil_read(`REG_IFETCH, 0, data, resp);
        check_value("fetches after clear", '0, data);
        axil_read(`REG_LOADS, 0, data, resp);
        check_value("loads after clear", '0, data);
        axil_read(`REG_STORES, 0, data, resp);
        check_value("stores after clear", '0, data);
        repeat (HOLD_CYCLES) @(posedge clk);
        #1;
        read_reg(`REG_IFETCH_LAT);
        read_reg(`REG_LOAD_LAT);
        drain();
        read_reg(`REG_IFETCH_LAT);
        read_reg(`REG_LOAD_LAT);
        end_test();

        start_test("back_pressure");
        axil_read(`REG_IFETCH_LAT, 6, lat_before, resp);
        axil_write(`AXIL_ADDR_BITS'h40, 32'h1, 5, resp);
        check_value("unmapped write response", RESP_SLVERR, resp);
        axil_read(`REG_IFETCH_LAT, 0, data, resp);
        check_value("latency after unmapped write", lat_before, data);
        axil_read(`AXIL_ADDR_BITS'h30, 4, data, resp);
        check_value("unmapped read data", '0, data);
        check_value("unmapped read response", RESP_SLVERR, resp);
        end_test();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 TEST_CYCLES * 2);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
